//--- filelist.f
source/axi_write_pkg.sv
source/demux_pkg.sv
source/id_lookup_if.sv
source/aw_dispatch.sv
source/id_table.sv
source/w_steer.sv
source/b_arbiter.sv
source/write_demux.sv
bench/tb_write_demux.sv

//--- Bender.yml
package:
  name: write_demux

sources:
  - files:
      - source/axi_write_pkg.sv
      - source/demux_pkg.sv
      - source/id_lookup_if.sv
      - source/aw_dispatch.sv
      - source/id_table.sv
      - source/w_steer.sv
      - source/b_arbiter.sv
      - source/write_demux.sv
  - target: test
    files:
      - bench/tb_write_demux.sv

//--- bench/tb_write_demux.sv
// Write demux testbench
`timescale 1ns/1ps

module tb_write_demux import axi_write_pkg::*, demux_pkg::*; ();

  localparam int unsigned NumPorts   = 3;
  localparam int unsigned MaxTrans   = 8;
  localparam int unsigned LookBits   = 2;
  localparam int unsigned NumLook    = 2 ** LookBits;
  localparam int unsigned HalfPeriod = 20;
  localparam int unsigned RandWrites = 40;
  localparam int unsigned ConcWrites = 12;
  localparam int unsigned HoldWrites = 6;
  localparam int unsigned TotalTrans = RandWrites + ConcWrites + HoldWrites;
  // 40 cycles per write
  localparam int unsigned TimeoutCycles = 40 * TotalTrans;

  typedef struct packed {
    select_t port;
    w_chan_t chan;
  } w_beat_t;

  typedef struct packed {
    select_t    sel;
    logic [7:0] len;
  } w_job_t;

  typedef struct packed {
    id_t         id;
    logic [31:0] due;
    logic [1:0]  resp;
  } b_pend_t;

  logic                      clk_i, rst_n_i;
  aw_chan_t                  s_aw_chan_i;
  select_t                   s_aw_select_i;
  logic                      s_aw_valid_i, s_aw_ready_o;
  w_chan_t                   s_w_chan_i;
  logic                      s_w_valid_i, s_w_ready_o;
  b_chan_t                   s_b_chan_o;
  logic                      s_b_valid_o, s_b_ready_i;
  aw_chan_t [NumPorts-1:0]   m_aw_chan_o;
  logic     [NumPorts-1:0]   m_aw_valid_o, m_aw_ready_i;
  w_chan_t  [NumPorts-1:0]   m_w_chan_o;
  logic     [NumPorts-1:0]   m_w_valid_o, m_w_ready_i;
  b_chan_t  [NumPorts-1:0]   m_b_chan_i;
  logic     [NumPorts-1:0]   m_b_valid_i, m_b_ready_o;

  // ----------------------------------------
  // scoreboard state
  // ----------------------------------------
  logic [31:0]         lcg_state = 32'h9862_18d6;
  aw_chan_t            exp_aw_q [NumPorts][$];
  w_beat_t             exp_w_q [$];
  w_job_t              w_job_q [$];
  // per manager port the AWs seen, bursts done and Bs queued
  id_t                 mgr_aw_q [NumPorts][$];
  int unsigned         mgr_w_done [NumPorts];
  b_pend_t             b_pend_q [NumPorts][$];
  logic [NumPorts-1:0] b_fired;
  // writes in flight per look-up id and port
  int unsigned         open_cnt [NumLook][NumPorts];
  int unsigned         exp_b_cnt [2**IdWidth];
  // responses per id in the order the managers issue them
  logic [1:0]          exp_resp_q [2**IdWidth][$];
  int unsigned         cycle_cnt, err_cnt, sent_cnt, b_done, test_cnt, test_err_base;
  logic                bp_hold;

  write_demux #(
    .NumPorts (NumPorts),
    .MaxTrans (MaxTrans),
    .LookBits (LookBits)
  ) i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(HalfPeriod) clk_i = ~clk_i;
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // true with pct percent odds from the upper bits
  function automatic logic chance(input int unsigned pct);
    logic [31:0] r;
    r = lcg_next();
    return (r[31:16] % 100) < pct;
  endfunction

  task automatic value_error(input string msg);
    $display("ERR %0t: %s", $time, msg);
    err_cnt++;
  endtask

  task automatic protocol_error(input string msg);
    $display("protocol error at %0t: %s", $time, msg);
    err_cnt++;
  endtask

  // starts and returns on a falling edge
  task automatic send_write(input id_t id, input select_t sel, input logic [7:0] len);
    aw_chan_t chan;
    w_job_t   job;
    chan.id       = id;
    chan.addr     = lcg_next();
    chan.len      = len;
    chan.size     = 3'd2;
    chan.burst    = 2'b01;
    s_aw_chan_i   = chan;
    s_aw_select_i = sel;
    s_aw_valid_i  = 1'b1;
    @(posedge clk_i);
    while (!s_aw_ready_o) @(posedge clk_i);
    // accepted AW now owed to the selected port
    exp_aw_q[sel].push_back(chan);
    job.sel = sel;
    job.len = len;
    w_job_q.push_back(job);
    exp_b_cnt[id]++;
    sent_cnt++;
    @(negedge clk_i);
    s_aw_valid_i = 1'b0;
  endtask

  task automatic send_w_burst(input select_t sel, input logic [7:0] len);
    w_beat_t     beat;
    logic [31:0] r;
    for (int unsigned i = 0; i <= len; i++) begin
      r = lcg_next();
      s_w_chan_i.data = lcg_next();
      s_w_chan_i.strb = r[31:32-StrbWidth];
      s_w_chan_i.last = (i == len);
      s_w_valid_i     = 1'b1;
      // beat must leave on the port of its AW
      beat.port = sel;
      beat.chan = s_w_chan_i;
      exp_w_q.push_back(beat);
      @(posedge clk_i);
      while (!s_w_ready_o) @(posedge clk_i);
      @(negedge clk_i);
      s_w_valid_i = 1'b0;
    end
  endtask

  task automatic aw_stream(input int unsigned n, input int unsigned mode);
    logic [31:0] r;
    id_t         id;
    select_t     sel;
    logic [7:0]  len;
    for (int unsigned i = 0; i < n; i++) begin
      r = lcg_next();
      if (mode == 0) begin
        // any id to any port so ordering stalls are common
        id  = id_t'(r[19:16]);
        sel = select_t'(r[31:24] % NumPorts);
      end else begin
        // port tied to low id bits so nothing waits
        id  = id_t'(mode * 4 + i % NumPorts);
        sel = select_t'(i % NumPorts);
      end
      len = 8'(r[21:20]);
      send_write(id, sel, len);
    end
  endtask

  task automatic w_stream(input int unsigned n);
    w_job_t job;
    for (int unsigned i = 0; i < n; i++) begin
      while (w_job_q.size() == 0) @(negedge clk_i);
      job = w_job_q.pop_front();
      send_w_burst(job.sel, job.len);
    end
  endtask

  task automatic hold_b_ready();
    bp_hold     = 1'b1;
    s_b_ready_i = 1'b0;
    while (!s_b_valid_o) @(negedge clk_i);
    // keep a response waiting for a while
    repeat (12) @(negedge clk_i);
    bp_hold = 1'b0;
  endtask

  task automatic wait_drained();
    while (b_done < sent_cnt || exp_w_q.size() != 0) @(negedge clk_i);
    repeat (2) @(negedge clk_i);
    for (int p = 0; p < NumPorts; p++) begin
      assert (exp_aw_q[p].size() == 0)
        else protocol_error($sformatf("AWs for port %0d never arrived", p));
      assert (b_pend_q[p].size() == 0)
        else protocol_error($sformatf("B responses on port %0d never taken", p));
    end
    foreach (exp_b_cnt[i]) begin
      assert (exp_b_cnt[i] == 0)
        else protocol_error($sformatf("writes with ID %0h got no B", i));
    end
  endtask

  task automatic run_traffic(input int unsigned n, input int unsigned mode);
    fork
      aw_stream(n, mode);
      w_stream(n);
      if (mode == 2) hold_b_ready();
    join
    wait_drained();
  endtask

  task automatic check_reset_state();
    assert (s_aw_ready_o == 1'b1) else value_error("s_aw_ready_o low after reset");
    assert (s_w_ready_o == 1'b0) else value_error("s_w_ready_o high after reset");
    assert (s_b_valid_o == 1'b0) else value_error("s_b_valid_o high after reset");
    assert (m_aw_valid_o == '0) else value_error("manager AW valid after reset");
    assert (m_w_valid_o == '0) else value_error("manager W valid after reset");
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err_base);
    test_err_base = err_cnt;
  endtask

  // ----------------------------------------
  // manager models and b sink
  // ----------------------------------------
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      for (int p = 0; p < NumPorts; p++) begin
        m_aw_ready_i[p] = chance(70);
        m_w_ready_i[p]  = chance(75);
        if (b_fired[p]) begin
          m_b_valid_i[p] = 1'b0;
          b_fired[p]     = 1'b0;
        end
        // next B once its delay ran out
        if (!m_b_valid_i[p] && b_pend_q[p].size() != 0 && b_pend_q[p][0].due <= cycle_cnt) begin
          m_b_chan_i[p].id   = b_pend_q[p][0].id;
          m_b_chan_i[p].resp = b_pend_q[p][0].resp;
          m_b_valid_i[p]     = 1'b1;
        end
      end
      s_b_ready_i = bp_hold ? 1'b0 : chance(80);
    end
  end

  // ----------------------------------------
  // monitor on the rising edge
  // ----------------------------------------
  always @(posedge clk_i) begin
    logic [LookBits-1:0] lid;
    aw_chan_t            exp_aw;
    w_beat_t             exp_beat;
    b_pend_t             pend;
    logic [1:0]          exp_resp;
    if (rst_n_i) begin
      // ordering rule uses counts from before this edge
      for (int p = 0; p < NumPorts; p++) begin
        if (m_aw_valid_o[p]) begin
          lid = m_aw_chan_o[p].id[LookBits-1:0];
          for (int q = 0; q < NumPorts; q++) begin
            assert (q == p || open_cnt[lid][q] == 0)
              else value_error($sformatf("AW ID %0h on port %0d, still open on port %0d",
                                         lid, p, q));
          end
        end
      end
      for (int p = 0; p < NumPorts; p++) begin
        if (m_aw_valid_o[p] && m_aw_ready_i[p]) begin
          assert (exp_aw_q[p].size() != 0)
            else value_error($sformatf("unexpected AW on port %0d", p));
          if (exp_aw_q[p].size() != 0) begin
            exp_aw = exp_aw_q[p].pop_front();
            assert (m_aw_chan_o[p] == exp_aw)
              else value_error($sformatf("AW on port %0d is %h, expected %h",
                                         p, m_aw_chan_o[p], exp_aw));
          end
          mgr_aw_q[p].push_back(m_aw_chan_o[p].id);
          open_cnt[m_aw_chan_o[p].id[LookBits-1:0]][p]++;
        end
        if (m_w_valid_o[p] && m_w_ready_i[p]) begin
          assert (exp_w_q.size() != 0)
            else value_error($sformatf("unexpected W beat on port %0d", p));
          if (exp_w_q.size() != 0) begin
            exp_beat = exp_w_q.pop_front();
            assert (exp_beat.port == select_t'(p) && m_w_chan_o[p] == exp_beat.chan)
              else value_error($sformatf("W beat %h on port %0d, expected %h on port %0d",
                                         m_w_chan_o[p], p, exp_beat.chan, exp_beat.port));
          end
          if (m_w_chan_o[p].last) begin
            mgr_w_done[p]++;
          end
        end
        if (m_b_valid_i[p] && m_b_ready_o[p]) begin
          open_cnt[m_b_chan_i[p].id[LookBits-1:0]][p]--;
          void'(b_pend_q[p].pop_front());
          b_fired[p] = 1'b1;
        end
        // AW plus finished burst gives one B
        if (mgr_aw_q[p].size() != 0 && mgr_w_done[p] != 0) begin
          pend.id   = mgr_aw_q[p].pop_front();
          pend.due  = cycle_cnt + ((lcg_next() >> 16) % 6);
          pend.resp = 2'(lcg_next() >> 30);
          b_pend_q[p].push_back(pend);
          exp_resp_q[pend.id].push_back(pend.resp);
          mgr_w_done[p]--;
        end
      end
      if (s_b_valid_o && s_b_ready_i) begin
        assert (exp_b_cnt[s_b_chan_o.id] != 0)
          else value_error($sformatf("B with ID %0h has no open write", s_b_chan_o.id));
        if (exp_b_cnt[s_b_chan_o.id] != 0) begin
          exp_b_cnt[s_b_chan_o.id]--;
        end
        assert (exp_resp_q[s_b_chan_o.id].size() != 0)
          else value_error($sformatf("B with ID %0h never issued by a manager",
                                     s_b_chan_o.id));
        if (exp_resp_q[s_b_chan_o.id].size() != 0) begin
          exp_resp = exp_resp_q[s_b_chan_o.id].pop_front();
          assert (s_b_chan_o.resp == exp_resp)
            else value_error($sformatf("B resp %0d, expected %0d",
                                       s_b_chan_o.resp, exp_resp));
        end
        b_done++;
      end
    end
  end

  // ----------------------------------------
  // protocol checks
  // ----------------------------------------
  a_aw_one_port: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(m_aw_valid_o))
    else protocol_error("AW valid on more than one manager port");

  a_w_one_port: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(m_w_valid_o))
    else protocol_error("W valid on more than one manager port");

  for (genvar p = 0; p < NumPorts; p++) begin : gen_port_chk
    a_aw_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (m_aw_valid_o[p] && !m_aw_ready_i[p]) |=>
        (m_aw_valid_o[p] && $stable(m_aw_chan_o[p])))
      else protocol_error($sformatf("AW on port %0d dropped or changed before ready", p));
  end

  // b held stable while the subordinate stalls
  a_b_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (s_b_valid_o && !s_b_ready_i) |=> (s_b_valid_o && $stable(s_b_chan_o)))
    else protocol_error("B response dropped or changed under back-pressure");

  a_b_one_grant: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (s_b_valid_o && s_b_ready_i) |-> $onehot(m_b_ready_o))
    else protocol_error("B transfer did not accept exactly one manager");

  a_b_no_grant: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(s_b_valid_o && s_b_ready_i) |-> (m_b_ready_o == '0))
    else protocol_error("manager B accepted without a subordinate transfer");

  // ----------------------------------------
  // watchdog
  // ----------------------------------------
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("timeout: writes still open after %0d cycles", cycle_cnt);
      $display("Test FAILED");
      $finish;
    end
  end

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin
    s_aw_chan_i   = '0;
    s_aw_select_i = '0;
    s_aw_valid_i  = 1'b0;
    s_w_chan_i    = '0;
    s_w_valid_i   = 1'b0;
    s_b_ready_i   = 1'b0;
    m_aw_ready_i  = '0;
    m_w_ready_i   = '0;
    m_b_chan_i    = '0;
    m_b_valid_i   = '0;
    b_fired       = '0;
    bp_hold       = 1'b0;
    rst_n_i       = 1'b0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    check_reset_state();
    end_test("reset state");
    run_traffic(RandWrites, 0);
    end_test("random routing and ordering");
    run_traffic(ConcWrites, 1);
    end_test("distinct ids in parallel");
    run_traffic(HoldWrites, 2);
    end_test("b back-pressure");
    $display("summary: %0d tests, %0d writes, %0d errors", test_cnt, sent_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- source/write_demux.sv
// AXI write demux top
`timescale 1ns/1ps

module write_demux import axi_write_pkg::*, demux_pkg::*; #(
  parameter int unsigned NumPorts = 3,
  parameter int unsigned MaxTrans = 8,
  parameter int unsigned LookBits = 2
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // subordinate side
  input  aw_chan_t                  s_aw_chan_i,
  input  select_t                   s_aw_select_i,
  input  logic                      s_aw_valid_i,
  output logic                      s_aw_ready_o,
  input  w_chan_t                   s_w_chan_i,
  input  logic                      s_w_valid_i,
  output logic                      s_w_ready_o,
  output b_chan_t                   s_b_chan_o,
  output logic                      s_b_valid_o,
  input  logic                      s_b_ready_i,
  // manager side
  output aw_chan_t [NumPorts-1:0]   m_aw_chan_o,
  output logic     [NumPorts-1:0]   m_aw_valid_o,
  input  logic     [NumPorts-1:0]   m_aw_ready_i,
  output w_chan_t  [NumPorts-1:0]   m_w_chan_o,
  output logic     [NumPorts-1:0]   m_w_valid_o,
  input  logic     [NumPorts-1:0]   m_w_ready_i,
  input  b_chan_t  [NumPorts-1:0]   m_b_chan_i,
  input  logic     [NumPorts-1:0]   m_b_valid_i,
  output logic     [NumPorts-1:0]   m_b_ready_o
);

  aw_chan_t aw_chan;
  // dispatcher to w path
  logic     route_push, route_full;
  select_t  route_select;
  // b merge to id table
  logic     b_pop;
  id_t      b_pop_id;

  id_lookup_if #(.LookBits(LookBits)) lookup_bus ();

  // same aw payload on every port, valid picks one
  assign m_aw_chan_o = {NumPorts{aw_chan}};

  aw_dispatch #(
    .NumPorts (NumPorts),
    .LookBits (LookBits)
  ) i_aw_dispatch (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .s_aw_chan_i    (s_aw_chan_i),
    .s_aw_select_i  (s_aw_select_i),
    .s_aw_valid_i   (s_aw_valid_i),
    .s_aw_ready_o   (s_aw_ready_o),
    .m_aw_chan_o    (aw_chan),
    .m_aw_valid_o   (m_aw_valid_o),
    .m_aw_ready_i   (m_aw_ready_i),
    .lookup         (lookup_bus.dispatch),
    .route_push_o   (route_push),
    .route_select_o (route_select),
    .route_full_i   (route_full)
  );

  id_table #(
    .LookBits (LookBits),
    .MaxTrans (MaxTrans)
  ) i_id_table (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .lookup   (lookup_bus.lookup_table),
    .pop_i    (b_pop),
    .pop_id_i (b_pop_id)
  );

  w_steer #(
    .NumPorts (NumPorts),
    .MaxTrans (MaxTrans)
  ) i_w_steer (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .route_push_i   (route_push),
    .route_select_i (route_select),
    .route_full_o   (route_full),
    .s_w_chan_i     (s_w_chan_i),
    .s_w_valid_i    (s_w_valid_i),
    .s_w_ready_o    (s_w_ready_o),
    .m_w_chan_o     (m_w_chan_o),
    .m_w_valid_o    (m_w_valid_o),
    .m_w_ready_i    (m_w_ready_i)
  );

  b_arbiter #(
    .NumPorts (NumPorts)
  ) i_b_arbiter (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .m_b_chan_i  (m_b_chan_i),
    .m_b_valid_i (m_b_valid_i),
    .m_b_ready_o (m_b_ready_o),
    .s_b_chan_o  (s_b_chan_o),
    .s_b_valid_o (s_b_valid_o),
    .s_b_ready_i (s_b_ready_i),
    .pop_o       (b_pop),
    .pop_id_o    (b_pop_id)
  );

endmodule

//--- source/b_arbiter.sv
// B response merge
`timescale 1ns/1ps

module b_arbiter import axi_write_pkg::*, demux_pkg::*; #(
  parameter int unsigned NumPorts = 3
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // manager b
  input  b_chan_t [NumPorts-1:0]   m_b_chan_i,
  input  logic    [NumPorts-1:0]   m_b_valid_i,
  output logic    [NumPorts-1:0]   m_b_ready_o,
  // subordinate b
  output b_chan_t                  s_b_chan_o,
  output logic                     s_b_valid_o,
  input  logic                     s_b_ready_i,
  // id table pop
  output logic                     pop_o,
  output id_t                      pop_id_o
);

  logic    locked_q, rr_found;
  select_t last_q, lock_idx_q, rr_pick, grant_idx;

  // ----------------------------------------
  // round robin pick
  // ----------------------------------------
  // scan starts one past the last winner
  always_comb begin
    int unsigned cand;
    rr_found = 1'b0;
    rr_pick  = last_q;
    for (int unsigned k = 1; k <= NumPorts; k++) begin
      cand = (last_q + k) % NumPorts;
      if (!rr_found && m_b_valid_i[cand]) begin
        rr_found = 1'b1;
        rr_pick  = select_t'(cand);
      end
    end
  end

  // stalled choice stays until taken
  assign grant_idx   = locked_q ? lock_idx_q : rr_pick;
  assign s_b_valid_o = locked_q ? m_b_valid_i[lock_idx_q] : rr_found;
  assign s_b_chan_o  = m_b_chan_i[grant_idx];
  assign pop_o       = s_b_valid_o && s_b_ready_i;
  assign pop_id_o    = s_b_chan_o.id;
  assign m_b_ready_o = pop_o ? (NumPorts'(1) << grant_idx) : '0;

  // ----------------------------------------
  // lock and pointer
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      locked_q <= 1'b0;
      // port 0 first
      last_q   <= select_t'(NumPorts - 1);
    end else begin
      locked_q <= s_b_valid_o && !s_b_ready_i;
      if (pop_o) begin
        last_q <= grant_idx;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (s_b_valid_o) begin
      lock_idx_q <= grant_idx;
    end
  end

endmodule

//--- source/w_steer.sv
// W route FIFO and beat steering
`timescale 1ns/1ps

module w_steer import axi_write_pkg::*, demux_pkg::*; #(
  parameter int unsigned NumPorts = 3,
  parameter int unsigned MaxTrans = 8
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // route from the aw dispatcher
  input  logic                     route_push_i,
  input  select_t                  route_select_i,
  output logic                     route_full_o,
  // subordinate w
  input  w_chan_t                  s_w_chan_i,
  input  logic                     s_w_valid_i,
  output logic                     s_w_ready_o,
  // manager w
  output w_chan_t [NumPorts-1:0]   m_w_chan_o,
  output logic    [NumPorts-1:0]   m_w_valid_o,
  input  logic    [NumPorts-1:0]   m_w_ready_i
);

  localparam int unsigned PtrWidth = (MaxTrans > 1) ? $clog2(MaxTrans) : 1;
  localparam int unsigned CntWidth = $clog2(MaxTrans + 1);

  select_t             mem_q [MaxTrans];
  logic [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                empty, pop;
  select_t             head;

  // pointer step with wrap for any depth
  function automatic logic [PtrWidth-1:0] next_ptr(input logic [PtrWidth-1:0] ptr);
    logic [PtrWidth-1:0] nxt;
    nxt = (ptr == PtrWidth'(MaxTrans - 1)) ? '0 : ptr + 1'b1;
    return nxt;
  endfunction

  // ----------------------------------------
  // route fifo
  // ----------------------------------------
  assign empty        = count_q == '0;
  assign route_full_o = count_q == CntWidth'(MaxTrans);
  assign head         = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (route_push_i) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      unique case ({route_push_i, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (route_push_i) begin
      mem_q[wr_ptr_q] <= route_select_i;
    end
  end

  // ----------------------------------------
  // beat steering
  // ----------------------------------------
  assign m_w_chan_o = {NumPorts{s_w_chan_i}};

  always_comb begin
    m_w_valid_o = '0;
    s_w_ready_o = 1'b0;
    pop         = 1'b0;
    // no route yet, beats wait at the subordinate port
    if (!empty) begin
      m_w_valid_o[head] = s_w_valid_i;
      s_w_ready_o       = m_w_ready_i[head];
      // burst done, next route
      pop = s_w_valid_i && m_w_ready_i[head] && s_w_chan_i.last;
    end
  end

  // dispatcher stalls before the fifo overflows
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    route_push_i |-> !route_full_o);

endmodule

//--- source/id_table.sv
// In-flight ID table
`timescale 1ns/1ps

module id_table import axi_write_pkg::*, demux_pkg::*; #(
  parameter int unsigned LookBits = 2,
  parameter int unsigned MaxTrans = 8
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  // look-up and push from the aw side
  id_lookup_if.lookup_table lookup,
  // pop on a subordinate b transfer
  input  logic              pop_i,
  input  id_t               pop_id_i
);

  // one counter per value of the low id bits
  localparam int unsigned NumCounters = 2 ** LookBits;
  // must reach MaxTrans itself
  localparam int unsigned CntWidth    = $clog2(MaxTrans + 1);

  logic [NumCounters-1:0]    push_en, pop_en, busy, at_top;
  select_t [NumCounters-1:0] sel_vec;

  // ----------------------------------------
  // look-up, purely combinational
  // ----------------------------------------
  assign lookup.lookup_select = sel_vec[lookup.lookup_id];
  assign lookup.occupied      = busy[lookup.lookup_id];
  assign lookup.full          = |at_top;

  // ----------------------------------------
  // counters
  // ----------------------------------------
  for (genvar i = 0; i < NumCounters; i++) begin : gen_cnt
    logic [CntWidth-1:0] cnt_q;
    select_t             sel_q;

    assign push_en[i] = lookup.push && (lookup.push_id == LookBits'(i));
    assign pop_en[i]  = pop_i && (pop_id_i[LookBits-1:0] == LookBits'(i));
    assign busy[i]    = cnt_q != '0;
    assign at_top[i]  = cnt_q == CntWidth'(MaxTrans);
    assign sel_vec[i] = sel_q;

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        cnt_q <= '0;
      end else begin
        // push with pop on the same id leaves the count alone
        unique case ({push_en[i], pop_en[i]})
          2'b10:   cnt_q <= cnt_q + 1'b1;
          2'b01:   cnt_q <= cnt_q - 1'b1;
          default: cnt_q <= cnt_q;
        endcase
      end
    end

    // port last used by this id
    always_ff @(posedge clk_i) begin
      if (push_en[i]) begin
        sel_q <= lookup.push_select;
      end
    end

    // every b must belong to a dispatched aw
    a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      pop_en[i] |-> busy[i]);
  end

endmodule

//--- source/aw_dispatch.sv
// AW dispatcher
`timescale 1ns/1ps

module aw_dispatch import axi_write_pkg::*, demux_pkg::*; #(
  parameter int unsigned NumPorts = 3,
  parameter int unsigned LookBits = 2
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // subordinate aw
  input  aw_chan_t            s_aw_chan_i,
  input  select_t             s_aw_select_i,
  input  logic                s_aw_valid_i,
  output logic                s_aw_ready_o,
  // manager aw, payload shared by all ports
  output aw_chan_t            m_aw_chan_o,
  output logic [NumPorts-1:0] m_aw_valid_o,
  input  logic [NumPorts-1:0] m_aw_ready_i,
  // id table
  id_lookup_if.dispatch       lookup,
  // route fifo in the w path
  output logic                route_push_o,
  output select_t             route_select_o,
  input  logic                route_full_i
);

  typedef struct packed {
    aw_chan_t chan;
    select_t  sel;
  } aw_sel_t;

  // spill stages, a takes input, b catches a on stall
  aw_sel_t a_data_q, b_data_q, in_data, sp_data;
  logic    a_full_q, b_full_q;
  logic    a_fill, a_drain, b_fill, b_drain;
  logic    sp_valid, sp_ready;

  dispatch_state_e state_q, state_d;
  logic            id_ok, issue, push, aw_valid, aw_ready;

  // ----------------------------------------
  // spill register
  // ----------------------------------------
  assign in_data.chan = s_aw_chan_i;
  assign in_data.sel  = s_aw_select_i;
  assign s_aw_ready_o = !a_full_q || !b_full_q;
  assign a_fill       = s_aw_valid_i && s_aw_ready_o;
  // a empties whenever b is free
  assign a_drain      = a_full_q && !b_full_q;
  assign b_fill       = a_drain && !sp_ready;
  assign b_drain      = b_full_q && sp_ready;
  assign sp_valid     = a_full_q || b_full_q;
  // b is always older than a
  assign sp_data      = b_full_q ? b_data_q : a_data_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill) begin
        a_full_q <= 1'b1;
      end else if (a_drain) begin
        a_full_q <= 1'b0;
      end
      if (b_fill) begin
        b_full_q <= 1'b1;
      end else if (b_drain) begin
        b_full_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= in_data;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // ----------------------------------------
  // ordering check and handshake
  // ----------------------------------------
  assign lookup.lookup_id   = sp_data.chan.id[LookBits-1:0];
  assign lookup.push_id     = sp_data.chan.id[LookBits-1:0];
  assign lookup.push_select = sp_data.sel;
  assign lookup.push        = push;
  // same id may only stay on the port it already uses
  assign id_ok    = !lookup.occupied || (lookup.lookup_select == sp_data.sel);
  assign issue    = sp_valid && id_ok && !lookup.full && !route_full_i;
  assign aw_ready = m_aw_ready_i[sp_data.sel];

  always_comb begin
    state_d  = state_q;
    aw_valid = 1'b0;
    sp_ready = 1'b0;
    push     = 1'b0;
    unique case (state_q)
      IDLE: begin
        if (issue) begin
          aw_valid = 1'b1;
          // route and id go in on the first valid cycle only
          push     = 1'b1;
          if (aw_ready) begin
            sp_ready = 1'b1;
          end else begin
            state_d = LOCKED;
          end
        end
      end
      LOCKED: begin
        // valid held whatever the table says now
        aw_valid = 1'b1;
        if (aw_ready) begin
          sp_ready = 1'b1;
          state_d  = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // fan-out to the selected port
  assign m_aw_chan_o    = sp_data.chan;
  assign m_aw_valid_o   = aw_valid ? (NumPorts'(1) << sp_data.sel) : '0;
  assign route_push_o   = push;
  assign route_select_o = sp_data.sel;

  // ----------------------------------------
  // checks
  // ----------------------------------------
  // only existing ports may be addressed
  a_select_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    s_aw_valid_i |-> (s_aw_select_i < NumPorts));

  // raised valid and payload hold until the manager takes them
  a_aw_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (aw_valid && !aw_ready) |=> ($stable(m_aw_valid_o) && $stable(m_aw_chan_o)));

endmodule

//--- source/id_lookup_if.sv
// ID look-up port
`timescale 1ns/1ps

interface id_lookup_if import demux_pkg::*; #(
  parameter int unsigned LookBits = 2
) ();

  // look-up of the low ID bits
  logic [LookBits-1:0] lookup_id;
  select_t             lookup_select;
  logic                occupied;

  // push of a dispatched AW
  logic                push;
  logic [LookBits-1:0] push_id;
  select_t             push_select;

  // some counter at its limit
  logic                full;

  modport dispatch (
    output lookup_id, push, push_id, push_select,
    input  lookup_select, occupied, full
  );

  modport lookup_table (
    input  lookup_id, push, push_id, push_select,
    output lookup_select, occupied, full
  );

endinterface

//--- source/demux_pkg.sv
// Write demux control types
package demux_pkg;

  // ----------------------------------------
  // port selection
  // ----------------------------------------
  // upper bound on manager ports
  parameter int unsigned MaxPorts = 4;

  // manager port index, sized for the largest build
  typedef logic [$clog2(MaxPorts)-1:0] select_t;

  // ----------------------------------------
  // aw dispatcher
  // ----------------------------------------
  // IDLE: free to issue the next AW
  // LOCKED: AW valid raised, waiting for ready
  typedef enum logic {
    IDLE,
    LOCKED
  } dispatch_state_e;

endpackage

//--- source/axi_write_pkg.sv
// AXI write channel types
package axi_write_pkg;

  // ----------------------------------------
  // bus widths
  // ----------------------------------------
  parameter int unsigned IdWidth   = 4;
  parameter int unsigned AddrWidth = 32;
  parameter int unsigned DataWidth = 32;
  // one strobe bit per data byte
  parameter int unsigned StrbWidth = DataWidth / 8;

  typedef logic [IdWidth-1:0] id_t;

  // ----------------------------------------
  // channel payloads
  // ----------------------------------------
  // aw: address plus burst shape
  typedef struct packed {
    id_t                  id;
    logic [AddrWidth-1:0] addr;
    logic [7:0]           len;
    logic [2:0]           size;
    logic [1:0]           burst;
  } aw_chan_t;

  // w: one data beat
  typedef struct packed {
    logic [DataWidth-1:0] data;
    logic [StrbWidth-1:0] strb;
    logic                 last;
  } w_chan_t;

  // b: write response
  typedef struct packed {
    id_t        id;
    logic [1:0] resp;
  } b_chan_t;

endpackage
